// File: build.f
src/tap_pkg.sv
src/stream_skid.sv
src/stream_tap.sv
src/capture_fifo.sv
src/tap_regs.sv
src/stream_monitor_top.sv
dv/tb_clock.sv
dv/stream_monitor_tb.sv

// File: dv/stream_monitor_tb.sv
// testbench top with stimulus, APB tasks, frame model and checks for the stream monitor
`default_nettype none

module stream_monitor_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import tap_pkg::*;

    localparam int SEED          = 22;
    localparam int FIFO_DEPTH    = 16;
    localparam int STEP_TIMEOUT  = 200;
    localparam int APB_TIMEOUT   = 16;
    localparam int POLL_LIMIT    = 100;
    localparam int DRAIN_TIMEOUT = 2000;

    logic        clk;
    logic        rst;
    link_beat_t  link_in;
    logic        link_in_valid;
    logic        link_in_ready;
    link_beat_t  link_out;
    logic        link_out_valid;
    logic        link_out_ready;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;

    // model state
    link_beat_t  frame_q[$];
    link_beat_t  saved_q[$];
    link_beat_t  long_q[$];
    link_beat_t  sent_q[$];
    logic [9:0]  cap_q[$];

    int unsigned stall_pct;
    string       test_name = "reset";
    int          test_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    logic        timed_out = 1'b0;

    tb_clock u_clock (
        .clk (clk),
        .rst (rst)
    );

    stream_monitor_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_dut (
        .clk            (clk),
        .rst            (rst),
        .link_in        (link_in),
        .link_in_valid  (link_in_valid),
        .link_in_ready  (link_in_ready),
        .link_out       (link_out),
        .link_out_valid (link_out_valid),
        .link_out_ready (link_out_ready),
        .apb_req        (apb_req),
        .apb_rsp        (apb_rsp)
    );

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("mismatch %s: %s expected 0x%0h actual 0x%0h",
                     test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("%s: %s", test_name, what);
            test_errors++;
        end
    endtask

    // parks the calling process until the watchdog below ends the run
    task automatic fail_timeout(input string what);
        $display("timeout in %s: %s", test_name, what);
        timed_out = 1'b1;
        forever @(negedge clk);
    endtask

    initial begin
        wait (timed_out);
        $display("%0d tests finished, %0d failed, run stopped by a timeout",
                 tests_run, tests_failed);
        $display("TEST FAILED");
        $finish;
    end

    // sink with random back-pressure
    always @(negedge clk) begin
        link_out_ready = ($urandom % 100) >= stall_pct;
    end

    // every beat the sink takes must be the next beat sent
    always @(posedge clk) begin
        link_beat_t expected;
        if (!rst && link_out_valid && link_out_ready) begin
            check_true(sent_q.size() != 0, "link_out delivered a beat that was never sent");
            if (sent_q.size() != 0) begin
                expected = sent_q.pop_front();
                check_value("link_out beat", 32'(expected), 32'(link_out));
            end
        end
    end

    task automatic apb_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        int   cycles;
        logic done;
        cycles = 0;
        done   = 1'b0;
        rdata  = '0;
        err    = 1'b0;
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;
        while (!done) begin
            @(posedge clk);
            if (apb_rsp.pready) begin
                rdata = apb_rsp.prdata;
                err   = apb_rsp.pslverr;
                done  = 1'b1;
            end else begin
                cycles++;
                if (cycles > APB_TIMEOUT) begin
                    fail_timeout("pready never came");
                end
            end
        end
        // transfers have zero wait states
        check_value("APB wait states", 32'h0, 32'(cycles));
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata,
                             output logic err);
        logic [31:0] unused_rdata;
        apb_access(1'b1, addr, wdata, unused_rdata, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] rdata,
                            output logic err);
        apb_access(1'b0, addr, 32'h0, rdata, err);
    endtask

    task automatic make_frame(input int len);
        link_beat_t beat;
        frame_q.delete();
        for (int i = 0; i < len; i++) begin
            beat.data = 8'($urandom);
            beat.last = (i == len - 1);
            beat.user = 1'($urandom);
            frame_q.push_back(beat);
        end
    endtask

    task automatic send_frame();
        int cycles;
        for (int i = 0; i < frame_q.size(); i++) begin
            @(negedge clk);
            link_in       = frame_q[i];
            link_in_valid = 1'b1;
            cycles        = 0;
            @(posedge clk);
            while (!link_in_ready) begin
                cycles++;
                if (cycles > STEP_TIMEOUT) begin
                    fail_timeout("link_in_ready stayed low");
                end
                @(posedge clk);
            end
            sent_q.push_back(frame_q[i]);
        end
        @(negedge clk);
        link_in_valid = 1'b0;
    endtask

    task automatic wait_link_drained();
        int cycles;
        cycles = 0;
        while (sent_q.size() != 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > DRAIN_TIMEOUT) begin
                fail_timeout("sink never took all sent beats");
            end
        end
    endtask

    // reads REG_DATA until a beat with last and retries empty reads
    task automatic drain_frame();
        logic [31:0] word;
        logic        err;
        logic        seen_last;
        int          polls;
        cap_q.delete();
        seen_last = 1'b0;
        polls     = 0;
        while (!seen_last) begin
            apb_read(REG_DATA, word, err);
            if (!err) begin
                cap_q.push_back(word[9:0]);
                seen_last = word[8];
            end
            polls++;
            if (polls > POLL_LIMIT) begin
                fail_timeout("no frame end read from REG_DATA");
            end
        end
    endtask

    task automatic wait_fifo_level(input logic [31:0] target);
        logic [31:0] word;
        logic        err;
        int          polls;
        polls = 0;
        apb_read(REG_STATUS, word, err);
        while (word != target) begin
            polls++;
            if (polls > POLL_LIMIT) begin
                fail_timeout("FIFO level never reached its target");
            end
            apb_read(REG_STATUS, word, err);
        end
    endtask

    task automatic check_clean_frame();
        check_value("captured beat count", 32'(frame_q.size()), 32'(cap_q.size()));
        for (int i = 0; i < frame_q.size() && i < cap_q.size(); i++) begin
            check_value("captured data", 32'(frame_q[i].data), 32'(cap_q[i][7:0]));
            check_value("captured last", 32'(i == frame_q.size() - 1), 32'(cap_q[i][8]));
            check_value("captured trunc", 32'h0, 32'(cap_q[i][9]));
        end
    endtask

    // prefix of the sent frame followed by one zero beat with last and trunc
    task automatic check_truncated_frame();
        int n;
        n = cap_q.size();
        check_true(n >= 1 && n <= frame_q.size(),
                   $sformatf("truncated capture has %0d beats for a %0d-beat frame",
                             n, frame_q.size()));
        if (n >= 1 && n <= frame_q.size()) begin
            for (int i = 0; i < n - 1; i++) begin
                check_value("prefix data", 32'(frame_q[i].data), 32'(cap_q[i][7:0]));
                check_value("prefix last", 32'h0, 32'(cap_q[i][8]));
                check_value("prefix trunc", 32'h0, 32'(cap_q[i][9]));
            end
            check_value("closing beat", 32'h300, 32'(cap_q[n-1]));
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", test_name, test_errors);
        end
    endtask

    task automatic test_clean_capture();
        logic [31:0] frames_before;
        logic [31:0] word;
        logic        err;
        int          nframes;
        start_test("clean_capture");
        stall_pct = 25;
        nframes   = 6;
        apb_write(REG_CTRL, 32'h1, err);
        apb_read(REG_FRAMES, frames_before, err);
        for (int f = 0; f < nframes; f++) begin
            make_frame(1 + int'($urandom % 12));
            send_frame();
            wait_link_drained();
            drain_frame();
            check_clean_frame();
        end
        apb_read(REG_FRAMES, word, err);
        check_value("REG_FRAMES", frames_before + 32'(nframes), word);
        finish_test();
    endtask

    task automatic test_truncation();
        logic [31:0] truncs_before;
        logic [31:0] word;
        logic        err;
        start_test("truncation");
        apb_read(REG_TRUNCS, truncs_before, err);
        // fill the FIFO with one clean frame and leave it there
        make_frame(FIFO_DEPTH);
        saved_q = frame_q;
        send_frame();
        wait_link_drained();
        wait_fifo_level(32'(FIFO_DEPTH));
        make_frame(8 + int'($urandom % 13));
        long_q = frame_q;
        send_frame();
        wait_link_drained();
        frame_q = saved_q;
        drain_frame();
        check_clean_frame();
        frame_q = long_q;
        drain_frame();
        check_truncated_frame();
        apb_read(REG_TRUNCS, word, err);
        check_value("REG_TRUNCS", truncs_before + 32'h1, word);
        // capture resumes with the next frame
        make_frame(1 + int'($urandom % 12));
        send_frame();
        wait_link_drained();
        drain_frame();
        check_clean_frame();
        finish_test();
    endtask

    task automatic test_disable();
        logic [31:0] frames_before;
        logic [31:0] word;
        logic        err;
        start_test("disable");
        apb_write(REG_CTRL, 32'h0, err);
        apb_read(REG_FRAMES, frames_before, err);
        for (int f = 0; f < 3; f++) begin
            make_frame(1 + int'($urandom % 12));
            send_frame();
            wait_link_drained();
        end
        // room for the tap and FIFO latency
        repeat (4) @(negedge clk);
        apb_read(REG_STATUS, word, err);
        check_value("REG_STATUS", 32'h0, word);
        apb_read(REG_FRAMES, word, err);
        check_value("REG_FRAMES", frames_before, word);
        finish_test();
    endtask

    task automatic test_transparency();
        logic [31:0] word;
        logic        err;
        int          polls;
        start_test("transparency");
        stall_pct = 50;
        apb_write(REG_CTRL, 32'h0, err);
        for (int f = 0; f < 4; f++) begin
            make_frame(1 + int'($urandom % 12));
            send_frame();
            wait_link_drained();
        end
        // short frames so the capture never overflows
        apb_write(REG_CTRL, 32'h1, err);
        for (int f = 0; f < 4; f++) begin
            make_frame(1 + int'($urandom % 4));
            send_frame();
            wait_link_drained();
        end
        apb_write(REG_CTRL, 32'h0, err);
        stall_pct = 0;
        repeat (4) @(negedge clk);
        polls = 0;
        err   = 1'b0;
        while (!err) begin
            apb_read(REG_DATA, word, err);
            polls++;
            if (polls > POLL_LIMIT) begin
                fail_timeout("capture FIFO never emptied");
            end
        end
        finish_test();
    endtask

    task automatic test_errors_and_ctrl();
        logic [31:0] word;
        logic        err;
        start_test("errors");
        apb_read(REG_DATA, word, err);
        check_value("pslverr on empty REG_DATA read", 32'h1, 32'(err));
        apb_read(8'h20, word, err);
        check_value("pslverr on unknown read", 32'h1, 32'(err));
        apb_write(8'h14, 32'h1, err);
        check_value("pslverr on unknown write", 32'h1, 32'(err));
        apb_write(REG_CTRL, 32'h1, err);
        apb_read(REG_CTRL, word, err);
        check_value("REG_CTRL pslverr", 32'h0, 32'(err));
        check_value("REG_CTRL enable set", 32'h1, 32'(word[0]));
        apb_write(REG_CTRL, 32'h0, err);
        apb_read(REG_CTRL, word, err);
        check_value("REG_CTRL enable clear", 32'h0, 32'(word[0]));
        finish_test();
    endtask

    initial begin
        int cycles;
        void'($urandom(SEED));
        link_in        = '0;
        link_in_valid  = 1'b0;
        link_out_ready = 1'b1;
        apb_req        = '0;
        stall_pct      = 0;
        cycles         = 0;
        // reset changes on the falling edge, so look at it on the rising one
        @(posedge clk);
        while (rst) begin
            @(posedge clk);
            cycles++;
            if (cycles > STEP_TIMEOUT) begin
                fail_timeout("reset was never released");
            end
        end
        test_clean_capture();
        test_truncation();
        test_disable();
        test_transparency();
        test_errors_and_ctrl();
        $display("%0d tests run, %0d passed, %0d failed",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/tb_clock.sv
// tb_clock: 40 ns testbench clock and a reset held for the first 16 cycles
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        // release away from the active edge
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
    --top-module stream_monitor_tb -f build.f -o sim_stream_monitor

./obj_dir/sim_stream_monitor > sim.log
cat sim.log

# the run passes only if the log holds the pass line
grep -qx "TEST OK" sim.log

// File: src/capture_fifo.sv
// capture_fifo: circular buffer of captured beats with fill level
`default_nettype none

module capture_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                              clk,
    input  logic                              rst,
    input  tap_pkg::cap_beat_t                wr_beat,
    input  logic                              wr_valid,
    output logic                              wr_ready,
    output tap_pkg::cap_beat_t                rd_beat,
    output logic                              rd_empty,
    input  logic                              rd_pop,
    output logic [$clog2(FIFO_DEPTH+1)-1:0]   level
);

    import tap_pkg::*;

    localparam int PTR_W   = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int LEVEL_W = $clog2(FIFO_DEPTH + 1);

    cap_beat_t          mem [FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [LEVEL_W-1:0] count_q;
    logic               wr_fire;
    logic               rd_fire;

    // wrap at the depth, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign wr_ready = (count_q != LEVEL_W'(FIFO_DEPTH));
    assign rd_empty = (count_q == '0);
    assign wr_fire  = wr_valid & wr_ready;
    assign rd_fire  = rd_pop & ~rd_empty;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (rd_fire) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            if (wr_fire && !rd_fire) begin
                count_q <= count_q + 1'b1;
            end else if (rd_fire && !wr_fire) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_ptr_q] <= wr_beat;
        end
    end

    assign rd_beat = mem[rd_ptr_q];
    assign level   = count_q;

endmodule

`default_nettype wire

// File: src/stream_monitor_top.sv
// stream_monitor_top: link stage, frame tap, capture FIFO and APB registers
`default_nettype none

module stream_monitor_top #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  tap_pkg::link_beat_t  link_in,
    input  logic                 link_in_valid,
    output logic                 link_in_ready,
    output tap_pkg::link_beat_t  link_out,
    output logic                 link_out_valid,
    input  logic                 link_out_ready,
    input  tap_pkg::apb_req_t    apb_req,
    output tap_pkg::apb_rsp_t    apb_rsp
);

    import tap_pkg::*;

    localparam int LEVEL_W = $clog2(FIFO_DEPTH + 1);

    cap_beat_t          cap;
    logic               cap_valid;
    logic               cap_ready;
    cap_beat_t          head;
    logic               empty;
    logic               pop;
    logic [LEVEL_W-1:0] level;
    logic               enable;
    tap_stats_t         stats;

    stream_skid #(
        .beat_t (link_beat_t)
    ) u_link (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (link_in),
        .in_valid  (link_in_valid),
        .in_ready  (link_in_ready),
        .out_beat  (link_out),
        .out_valid (link_out_valid),
        .out_ready (link_out_ready)
    );

    // tap watches the sink side of the link stage
    stream_tap u_tap (
        .clk       (clk),
        .rst       (rst),
        .enable    (enable),
        .mon_beat  (link_out),
        .mon_valid (link_out_valid),
        .mon_ready (link_out_ready),
        .cap       (cap),
        .cap_valid (cap_valid),
        .cap_ready (cap_ready),
        .stats     (stats)
    );

    capture_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr_beat  (cap),
        .wr_valid (cap_valid),
        .wr_ready (cap_ready),
        .rd_beat  (head),
        .rd_empty (empty),
        .rd_pop   (pop),
        .level    (level)
    );

    tap_regs #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_regs (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .enable  (enable),
        .stats   (stats),
        .head    (head),
        .empty   (empty),
        .level   (level),
        .pop     (pop)
    );

endmodule

`default_nettype wire

// File: src/stream_skid.sv
// stream_skid: two-entry registered valid/ready stage for any payload type
`default_nettype none

module stream_skid #(
    parameter type beat_t = logic
) (
    input  logic  clk,
    input  logic  rst,
    input  beat_t in_beat,
    input  logic  in_valid,
    output logic  in_ready,
    output beat_t out_beat,
    output logic  out_valid,
    input  logic  out_ready
);

    beat_t out_beat_q;
    beat_t temp_beat_q;
    logic  out_valid_q;
    logic  temp_valid_q;
    logic  ready_q;
    logic  ready_early;
    logic  load_out;
    logic  load_temp;
    logic  drain_temp;

    // ready for next cycle when the sink drains, or the temp slot stays free
    assign ready_early = out_ready | (~temp_valid_q & ~out_valid_q) |
                         (~temp_valid_q & ~in_valid);

    assign load_out   = ready_q & (out_ready | ~out_valid_q);
    assign load_temp  = ready_q & ~(out_ready | ~out_valid_q);
    assign drain_temp = ~ready_q & out_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ready_q      <= 1'b0;
            out_valid_q  <= 1'b0;
            temp_valid_q <= 1'b0;
        end else begin
            ready_q <= ready_early;
            if (load_out) begin
                out_valid_q <= in_valid;
            end else if (load_temp) begin
                temp_valid_q <= in_valid;
            end else if (drain_temp) begin
                out_valid_q  <= temp_valid_q;
                temp_valid_q <= 1'b0;
            end
        end
    end

    // payload registers follow the valid flags
    always_ff @(posedge clk) begin
        if (load_out) begin
            out_beat_q <= in_beat;
        end else if (load_temp) begin
            temp_beat_q <= in_beat;
        end else if (drain_temp) begin
            out_beat_q <= temp_beat_q;
        end
    end

    assign in_ready  = ready_q;
    assign out_beat  = out_beat_q;
    assign out_valid = out_valid_q;

endmodule

`default_nettype wire

// File: src/stream_tap.sv
// stream_tap: passive frame tap with truncation FSM, frame counters and output skid
`default_nettype none

module stream_tap (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  enable,
    input  tap_pkg::link_beat_t   mon_beat,
    input  logic                  mon_valid,
    input  logic                  mon_ready,
    output tap_pkg::cap_beat_t    cap,
    output logic                  cap_valid,
    input  logic                  cap_ready,
    output tap_pkg::tap_stats_t   stats
);

    import tap_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_TRANSFER,
        ST_TRUNCATE,
        ST_WAIT
    } state_t;

    state_t      state_q;
    state_t      state_next;
    logic        frame_q;
    logic        frame_next;
    logic        accept;
    cap_beat_t   int_beat;
    logic        int_valid;
    logic        int_ready;
    logic [15:0] frames_q;
    logic [15:0] truncs_q;

    assign accept = mon_valid & mon_ready;

    always_comb begin
        state_next = state_q;
        frame_next = frame_q;
        int_beat   = '0;
        int_valid  = 1'b0;

        // link frame tracking, independent of capture
        if (accept) begin
            frame_next = ~mon_beat.last;
        end

        case (state_q)
            ST_IDLE: begin
                if (accept) begin
                    if (int_ready && enable) begin
                        int_beat.data = mon_beat.data;
                        int_beat.last = mon_beat.last;
                        int_valid     = 1'b1;
                        state_next    = mon_beat.last ? ST_IDLE : ST_TRANSFER;
                    end else begin
                        // skip the whole frame
                        state_next = mon_beat.last ? ST_IDLE : ST_WAIT;
                    end
                end
            end
            ST_TRANSFER: begin
                if (accept) begin
                    if (int_ready) begin
                        int_beat.data = mon_beat.data;
                        int_beat.last = mon_beat.last;
                        int_valid     = 1'b1;
                        state_next    = mon_beat.last ? ST_IDLE : ST_TRANSFER;
                    end else begin
                        state_next = ST_TRUNCATE;
                    end
                end
            end
            ST_TRUNCATE: begin
                if (int_ready) begin
                    // zero-data closing beat
                    int_beat.last  = 1'b1;
                    int_beat.trunc = 1'b1;
                    int_valid      = 1'b1;
                    state_next     = frame_next ? ST_WAIT : ST_IDLE;
                end
            end
            default: begin
                if (accept && mon_beat.last) begin
                    state_next = ST_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q  <= ST_IDLE;
            frame_q  <= 1'b0;
            frames_q <= '0;
            truncs_q <= '0;
        end else begin
            state_q <= state_next;
            frame_q <= frame_next;
            if (int_valid && int_beat.last && !int_beat.trunc) begin
                frames_q <= frames_q + 16'd1;
            end
            if (int_valid && int_beat.trunc) begin
                truncs_q <= truncs_q + 16'd1;
            end
        end
    end

    assign stats.frames = frames_q;
    assign stats.truncs = truncs_q;

    stream_skid #(
        .beat_t (cap_beat_t)
    ) u_cap_skid (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (int_beat),
        .in_valid  (int_valid),
        .in_ready  (int_ready),
        .out_beat  (cap),
        .out_valid (cap_valid),
        .out_ready (cap_ready)
    );

endmodule

`default_nettype wire

// File: src/tap_pkg.sv
// tap_pkg: beat structs, stats struct, APB structs and register offsets
`default_nettype none

package tap_pkg;

    localparam int DATA_WIDTH = 8;

    // one beat on the monitored link
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic                  last;
        logic                  user;
    } link_beat_t;

    // one beat in the capture path, trunc marks an early close
    typedef struct packed {
        logic                  trunc;
        logic                  last;
        logic [DATA_WIDTH-1:0] data;
    } cap_beat_t;

    typedef struct packed {
        logic [15:0] frames;
        logic [15:0] truncs;
    } tap_stats_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // register map
    localparam logic [7:0] REG_CTRL   = 8'h00;
    localparam logic [7:0] REG_STATUS = 8'h04;
    localparam logic [7:0] REG_FRAMES = 8'h08;
    localparam logic [7:0] REG_TRUNCS = 8'h0C;
    localparam logic [7:0] REG_DATA   = 8'h10;

endpackage

`default_nettype wire

// File: src/tap_regs.sv
// tap_regs: APB slave with control, status, counters and data-pop register
`default_nettype none

module tap_regs #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                              clk,
    input  logic                              rst,
    input  tap_pkg::apb_req_t                 apb_req,
    output tap_pkg::apb_rsp_t                 apb_rsp,
    output logic                              enable,
    input  tap_pkg::tap_stats_t               stats,
    input  tap_pkg::cap_beat_t                head,
    input  logic                              empty,
    input  logic [$clog2(FIFO_DEPTH+1)-1:0]   level,
    output logic                              pop
);

    import tap_pkg::*;

    logic        enable_q;
    logic        access;
    logic        rd_access;
    logic        wr_access;
    logic [31:0] rdata;
    logic        err;

    // access phase of a transfer, always zero wait states
    assign access    = apb_req.psel & apb_req.penable;
    assign rd_access = access & ~apb_req.pwrite;
    assign wr_access = access & apb_req.pwrite;

    always_comb begin
        rdata = '0;
        err   = 1'b0;
        case (apb_req.paddr)
            REG_CTRL: begin
                rdata[0] = enable_q;
            end
            REG_STATUS: begin
                rdata = 32'(level);
            end
            REG_FRAMES: begin
                rdata[15:0] = stats.frames;
            end
            REG_TRUNCS: begin
                rdata[15:0] = stats.truncs;
            end
            REG_DATA: begin
                rdata[7:0] = head.data;
                rdata[8]   = head.last;
                rdata[9]   = head.trunc;
                // reading an empty FIFO is an error, writes are ignored
                if (!apb_req.pwrite && empty) begin
                    err = 1'b1;
                end
            end
            default: begin
                err = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            enable_q <= 1'b0;
        end else if (wr_access && apb_req.paddr == REG_CTRL) begin
            enable_q <= apb_req.pwdata[0];
        end
    end

    // head leaves the FIFO at the edge that ends the access phase
    assign pop = rd_access & (apb_req.paddr == REG_DATA) & ~empty;

    assign apb_rsp.prdata  = rd_access ? rdata : '0;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = access & err;

    assign enable = enable_q;

endmodule

`default_nettype wire
